// ==== vlog.f ====
+incdir+common
common/sys_ctrl_pkg.sv
common/fence_req_if.sv
main_cu/fence_decoder.sv
main_cu/main_cu.sv
logic/flush_sequencer.sv
logic/sys_ctrl_top.sv
dv/tb_sys_ctrl.sv

// ==== Makefile ====
TOOL     = verilator
TOP      = tb_sys_ctrl
FILELIST = vlog.f
FLAGS    = --binary -j 0 --timescale 1ns/100ps --top-module $(TOP)
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dv/tb_sys_ctrl.sv ====
// Directed testbench for sys_ctrl_top with memory responder, LFSR, compare tasks and watchdog
`default_nettype none

`include "sys_ctrl_defines.svh"

module tb_sys_ctrl
	import sys_ctrl_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 4;
	localparam int NUM_TESTS  = 5;
	localparam int WATCHDOG_NS = NUM_TESTS * 200 * CLK_PERIOD;
	// Upper bound on cycles from acceptance to the refetch flush
	localparam int SEQ_LIMIT  = 64;

	// RV64 encodings of add a0 a0 a1, full fence and fence.i
	localparam logic [31:0] ADD_INS     = 32'h00b50533;
	localparam logic [31:0] FENCE_INS   = 32'h0ff0000f;
	localparam logic [31:0] FENCE_I_INS = 32'h0000100f;
	// Operands with junk above the used fields
	localparam logic [63:0] VA_VAL   = 64'hffff_ff92_3456_7abc;
	localparam logic [63:0] ASID_VAL = 64'hdead_beef_0000_5a3c;

	logic clk_i = 1'b0;
	logic rst_n_i;
	logic fe_valid_i;
	logic [`SC_ILEN-1:0] fe_ins_i;
	logic [`SC_XLEN-1:0] fe_rs1_i;
	logic [`SC_XLEN-1:0] fe_rs2_i;
	logic fe_except_i;
	logic fe_ready_o;
	logic be_stall_i;
	logic be_flush_i;
	logic stall_o;
	logic flush_o;
	logic mem_done_i;
	logic mem_synch_l1dc_l2c_o;
	logic mem_flush_o;
	logic mem_clr_mshr_o;
	logic mem_tlb_flush_o;
	tlb_flush_e mem_tlb_flush_type_o;
	asid_t mem_flush_asid_o;
	vpn_t mem_flush_page_o;

	// Responder log with one letter per command (S sync, I icache, C mshr, T tlb)
	string cmd_log = "";
	tlb_flush_e tlb_seen = NO_FLUSH;
	asid_t asid_seen = '0;
	vpn_t page_seen = '0;
	logic [31:0] lfsr_q = 32'ha927_8c7e;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	sys_ctrl_top uut (.*);

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit
	task automatic take_bits(input int n, output logic [63:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[62:0], lfsr_q[31]};
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	function automatic logic [31:0] sfence_ins(input logic [4:0] rs1_idx,
			input logic [4:0] rs2_idx);
		return {7'b0001001, rs2_idx, rs1_idx, 3'b000, 5'b00000, 7'b1110011};
	endfunction

	// Memory side model answering after 0 to 7 cycles
	initial begin : responder
		logic [63:0] dly;
		int delay;
		logic busy;
		logic held;
		mem_done_i = 1'b0;
		busy = 1'b0;
		delay = 0;
		forever begin
			@(negedge clk_i);
			mem_done_i = 1'b0;
			held = mem_synch_l1dc_l2c_o || mem_flush_o || mem_tlb_flush_o;
			if (rst_n_i) begin
				if (int'(mem_synch_l1dc_l2c_o) + int'(mem_flush_o) + int'(mem_clr_mshr_o)
						+ int'(mem_tlb_flush_o) > 1) begin
					$display("ERROR: more than one memory command high at %0t", $time);
					errors++;
				end
				if (busy && !held) begin
					$display("ERROR: memory command dropped before done at %0t", $time);
					errors++;
					busy = 1'b0;
				end
				// MSHR clear is a pulse and gets logged on every cycle it is seen
				if (mem_clr_mshr_o) cmd_log = {cmd_log, "C"};
				if (!busy && held) begin
					if (mem_synch_l1dc_l2c_o) cmd_log = {cmd_log, "S"};
					if (mem_flush_o) cmd_log = {cmd_log, "I"};
					if (mem_tlb_flush_o) begin
						cmd_log = {cmd_log, "T"};
						tlb_seen = mem_tlb_flush_type_o;
						asid_seen = mem_flush_asid_o;
						page_seen = mem_flush_page_o;
					end
					take_bits(3, dly);
					delay = int'(dly[2:0]);
					busy = 1'b1;
				end
				if (busy) begin
					if (delay == 0) begin
						mem_done_i = 1'b1;
						busy = 1'b0;
					end else begin
						delay--;
					end
				end
			end
		end
	end

	task automatic check_bit(input string name, input string sig, input logic exp,
			input logic act);
		if (act !== exp) begin
			$display("FAILED %s: %s expected %b actual %b", name, sig, exp, act);
			errors++;
		end
	endtask

	task automatic check_kind_seq(input string name, input string exp);
		if (cmd_log != exp) begin
			$display("FAILED %s: commands expected \"%s\" actual \"%s\"", name, exp, cmd_log);
			errors++;
		end
	endtask

	task automatic check_tlb(input string name, input tlb_flush_e exp_type, input asid_t exp_asid,
			input vpn_t exp_page, input tlb_flush_e act_type, input asid_t act_asid,
			input vpn_t act_page);
		if (act_type !== exp_type || act_asid !== exp_asid || act_page !== exp_page) begin
			$display("FAILED %s: tlb expected %s/%h/%h actual %s/%h/%h", name, exp_type.name(),
				exp_asid, exp_page, act_type.name(), act_asid, act_page);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int start_errors);
		tests_run++;
		if (errors == start_errors) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - start_errors);
		end
	endtask

	// Called at a falling edge and returns in the cycle after acceptance
	task automatic send_ins(input logic [31:0] ins, input logic [63:0] rs1,
			input logic [63:0] rs2, input logic exc);
		if (fe_ready_o !== 1'b1) begin
			$display("ERROR: front end not ready for instruction %h", ins);
			errors++;
		end
		fe_valid_i = 1'b1;
		fe_ins_i = ins;
		fe_rs1_i = rs1;
		fe_rs2_i = rs2;
		fe_except_i = exc;
		@(negedge clk_i);
		fe_valid_i = 1'b0;
		fe_except_i = 1'b0;
	endtask

	task automatic run_fence(input string name, input logic [31:0] ins, input logic [63:0] rs1,
			input logic [63:0] rs2, input string exp_seq);
		int cyc;
		cmd_log = "";
		tlb_seen = NO_FLUSH;
		asid_seen = '0;
		page_seen = '0;
		send_ins(ins, rs1, rs2, 1'b0);
		check_bit(name, "stall_o", 1'b1, stall_o);
		cyc = 0;
		// Stall must hold until the refetch flush
		while (flush_o !== 1'b1 && cyc < SEQ_LIMIT) begin
			check_bit(name, "stall_o", 1'b1, stall_o);
			check_bit(name, "fe_ready_o", 1'b0, fe_ready_o);
			@(negedge clk_i);
			cyc++;
		end
		if (cyc == SEQ_LIMIT) begin
			$display("ERROR: %s never ended with a flush pulse", name);
			errors++;
		end
		check_bit(name, "stall_o", 1'b0, stall_o);
		@(negedge clk_i);
		check_bit(name, "flush_o", 1'b0, flush_o);
		check_kind_seq(name, exp_seq);
	endtask

	// x0 reads as zero so its operand value is zero
	task automatic run_sfence(input string name, input logic [4:0] rs1_idx,
			input logic [4:0] rs2_idx, input tlb_flush_e exp_type);
		logic [63:0] rs1;
		logic [63:0] rs2;
		rs1 = (rs1_idx != 5'd0) ? VA_VAL : 64'h0;
		rs2 = (rs2_idx != 5'd0) ? ASID_VAL : 64'h0;
		run_fence(name, sfence_ins(rs1_idx, rs2_idx), rs1, rs2, "CT");
		check_tlb(name, exp_type, asid_t'(rs2[15:0]), vpn_t'(rs1[38:12]),
			tlb_seen, asid_seen, page_seen);
	endtask

	task automatic reset_and_ordinary();
		int start;
		start = errors;
		check_bit("reset", "fe_ready_o", 1'b1, fe_ready_o);
		check_bit("reset", "stall_o", 1'b0, stall_o);
		check_bit("reset", "flush_o", 1'b0, flush_o);
		check_bit("reset", "mem_synch_l1dc_l2c_o", 1'b0, mem_synch_l1dc_l2c_o);
		check_bit("reset", "mem_flush_o", 1'b0, mem_flush_o);
		check_bit("reset", "mem_clr_mshr_o", 1'b0, mem_clr_mshr_o);
		check_bit("reset", "mem_tlb_flush_o", 1'b0, mem_tlb_flush_o);
		check_tlb("reset", NO_FLUSH, '0, '0, mem_tlb_flush_type_o, mem_flush_asid_o,
			mem_flush_page_o);
		cmd_log = "";
		send_ins(ADD_INS, 64'h1, 64'h2, 1'b0);
		repeat (3) begin
			check_bit("reset", "stall_o", 1'b0, stall_o);
			check_bit("reset", "flush_o", 1'b0, flush_o);
			@(negedge clk_i);
		end
		check_kind_seq("reset", "");
		report_test("reset", start);
	endtask

	task automatic fence_and_fence_i();
		int start;
		start = errors;
		run_fence("fence", FENCE_INS, 64'h0, 64'h0, "S");
		run_fence("fence.i", FENCE_I_INS, 64'h0, 64'h0, "SI");
		report_test("fence", start);
	endtask

	task automatic sfence_combos();
		int start;
		start = errors;
		run_sfence("sfence_all", 5'd0, 5'd0, FLUSH_ALL);
		run_sfence("sfence_asid", 5'd0, 5'd6, FLUSH_ASID);
		run_sfence("sfence_page", 5'd5, 5'd0, FLUSH_PAGE);
		run_sfence("sfence_page_asid", 5'd5, 5'd6, FLUSH_PAGE_ASID);
		report_test("sfence", start);
	endtask

	task automatic exception_and_be_flush();
		int start;
		start = errors;
		cmd_log = "";
		send_ins(FENCE_I_INS, 64'h0, 64'h0, 1'b1);
		check_bit("except", "flush_o", 1'b1, flush_o);
		check_bit("except", "stall_o", 1'b0, stall_o);
		@(negedge clk_i);
		check_bit("except", "flush_o", 1'b0, flush_o);
		@(negedge clk_i);
		check_kind_seq("except", "");
		// Back-end flush shows in the same cycle
		be_flush_i = 1'b1;
		#1;
		check_bit("be_flush", "flush_o", 1'b1, flush_o);
		@(negedge clk_i);
		be_flush_i = 1'b0;
		#1;
		check_bit("be_flush", "flush_o", 1'b0, flush_o);
		check_bit("be_flush", "stall_o", 1'b0, stall_o);
		@(negedge clk_i);
		report_test("except", start);
	endtask

	task automatic back_pressure();
		int start;
		start = errors;
		cmd_log = "";
		be_stall_i = 1'b1;
		fe_valid_i = 1'b1;
		fe_ins_i = FENCE_INS;
		repeat (4) begin
			@(negedge clk_i);
			check_bit("backpressure", "fe_ready_o", 1'b0, fe_ready_o);
			check_bit("backpressure", "stall_o", 1'b0, stall_o);
		end
		fe_valid_i = 1'b0;
		be_stall_i = 1'b0;
		@(negedge clk_i);
		check_kind_seq("backpressure", "");
		// Random done delays stretch each command
		repeat (4) run_fence("backpressure", FENCE_I_INS, 64'h0, 64'h0, "SI");
		report_test("backpressure", start);
	endtask

	initial begin
		rst_n_i = 1'b0;
		fe_valid_i = 1'b0;
		fe_ins_i = '0;
		fe_rs1_i = '0;
		fe_rs2_i = '0;
		fe_except_i = 1'b0;
		be_stall_i = 1'b0;
		be_flush_i = 1'b0;
		repeat (3) @(negedge clk_i);
		rst_n_i = 1'b1;
		repeat (2) @(negedge clk_i);
		reset_and_ordinary();
		fence_and_fence_i();
		sfence_combos();
		exception_and_be_flush();
		back_pressure();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// Watchdog sized from the test count
	initial begin
		#(WATCHDOG_NS);
		$display("ERROR: run did not finish within %0d ns", WATCHDOG_NS);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/sys_ctrl_top.sv ====
// System control top level joining main control unit and flush sequencer
`default_nettype none

`include "sys_ctrl_defines.svh"

module sys_ctrl_top
	import sys_ctrl_pkg::*;
(
	input  logic                clk_i,
	input  logic                rst_n_i,

	// Front end
	input  logic                fe_valid_i,
	input  logic [`SC_ILEN-1:0] fe_ins_i,
	input  logic [`SC_XLEN-1:0] fe_rs1_i,
	input  logic [`SC_XLEN-1:0] fe_rs2_i,
	input  logic                fe_except_i,
	output logic                fe_ready_o,

	// Back end
	input  logic                be_stall_i,
	input  logic                be_flush_i,
	output logic                stall_o,
	output logic                flush_o,

	// Memory side
	input  logic                mem_done_i,
	output logic                mem_synch_l1dc_l2c_o,
	output logic                mem_flush_o,
	output logic                mem_clr_mshr_o,
	output logic                mem_tlb_flush_o,
	output tlb_flush_e          mem_tlb_flush_type_o,
	output asid_t               mem_flush_asid_o,
	output vpn_t                mem_flush_page_o
);

	// Fence request channel
	fence_req_if u_req_if ();

	main_cu u_main_cu (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.fe_valid_i  (fe_valid_i),
		.fe_ins_i    (fe_ins_i),
		.fe_rs1_i    (fe_rs1_i),
		.fe_rs2_i    (fe_rs2_i),
		.fe_except_i (fe_except_i),
		.fe_ready_o  (fe_ready_o),
		.be_stall_i  (be_stall_i),
		.be_flush_i  (be_flush_i),
		.stall_o     (stall_o),
		.flush_o     (flush_o),
		.req         (u_req_if.cu)
	);

	flush_sequencer u_flush_sequencer (
		.clk_i                (clk_i),
		.rst_n_i              (rst_n_i),
		.req                  (u_req_if.seq),
		.mem_done_i           (mem_done_i),
		.mem_synch_l1dc_l2c_o (mem_synch_l1dc_l2c_o),
		.mem_flush_o          (mem_flush_o),
		.mem_clr_mshr_o       (mem_clr_mshr_o),
		.mem_tlb_flush_o      (mem_tlb_flush_o),
		.mem_tlb_flush_type_o (mem_tlb_flush_type_o),
		.mem_flush_asid_o     (mem_flush_asid_o),
		.mem_flush_page_o     (mem_flush_page_o)
	);

endmodule

`default_nettype wire

// ==== logic/flush_sequencer.sv ====
// Flush sequencer FSM stepping through the memory-maintenance commands of one fence request
`default_nettype none

module flush_sequencer
	import sys_ctrl_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_n_i,

	// Request from control unit
	fence_req_if.seq   req,

	// Memory side
	input  logic       mem_done_i,
	output logic       mem_synch_l1dc_l2c_o,
	output logic       mem_flush_o,
	output logic       mem_clr_mshr_o,
	output logic       mem_tlb_flush_o,
	output tlb_flush_e mem_tlb_flush_type_o,
	output asid_t      mem_flush_asid_o,
	output vpn_t       mem_flush_page_o
);

	seq_state_e state_q;
	seq_state_e state_d;
	fence_op_t  op_q;
	logic       req_take;

	// Only accept while idle
	assign req.ready = (state_q == IDLE);
	assign req_take  = req.valid && req.ready;
	assign req.done  = (state_q == DONE);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// Latch request on acceptance
	always_ff @(posedge clk_i) begin
		if (req_take) begin
			op_q <= req.op;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (req_take) begin
					case (req.op.kind)
						FENCE, FENCE_I: state_d = SYNC;
						SFENCE_VMA:     state_d = CLR_MSHR;
						// Nothing to do, just report done
						default:        state_d = DONE;
					endcase
				end
			end
			SYNC: begin
				if (mem_done_i) begin
					state_d = (op_q.kind == FENCE_I) ? IFLUSH : DONE;
				end
			end
			IFLUSH: begin
				if (mem_done_i) begin
					state_d = DONE;
				end
			end
			// MSHR clear needs no done
			CLR_MSHR: begin
				state_d = TLB;
			end
			TLB: begin
				if (mem_done_i) begin
					state_d = DONE;
				end
			end
			DONE: begin
				state_d = IDLE;
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	// Commands registered from next state, one at a time
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mem_synch_l1dc_l2c_o <= 1'b0;
			mem_flush_o          <= 1'b0;
			mem_clr_mshr_o       <= 1'b0;
			mem_tlb_flush_o      <= 1'b0;
			mem_tlb_flush_type_o <= NO_FLUSH;
			mem_flush_asid_o     <= '0;
			mem_flush_page_o     <= '0;
		end else begin
			mem_synch_l1dc_l2c_o <= (state_d == SYNC);
			mem_flush_o          <= (state_d == IFLUSH);
			mem_clr_mshr_o       <= (state_d == CLR_MSHR);
			mem_tlb_flush_o      <= (state_d == TLB);
			// TLB qualifiers only valid alongside the flush
			if (state_d == TLB) begin
				mem_tlb_flush_type_o <= op_q.tlb;
				mem_flush_asid_o     <= op_q.asid;
				mem_flush_page_o     <= op_q.vpn;
			end else begin
				mem_tlb_flush_type_o <= NO_FLUSH;
				mem_flush_asid_o     <= '0;
				mem_flush_page_o     <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== main_cu/main_cu.sv ====
// Main control unit FSM for front-end handshake, stall, flush and fence request issue
`default_nettype none

`include "sys_ctrl_defines.svh"

module main_cu
	import sys_ctrl_pkg::*;
(
	input  logic                clk_i,
	input  logic                rst_n_i,

	// Front end
	input  logic                fe_valid_i,
	input  logic [`SC_ILEN-1:0] fe_ins_i,
	input  logic [`SC_XLEN-1:0] fe_rs1_i,
	input  logic [`SC_XLEN-1:0] fe_rs2_i,
	input  logic                fe_except_i,
	output logic                fe_ready_o,

	// Back end
	input  logic                be_stall_i,
	input  logic                be_flush_i,

	// Pipeline control
	output logic                stall_o,
	output logic                flush_o,

	// Request to sequencer
	fence_req_if.cu             req
);

	cu_state_e state_q;
	cu_state_e state_d;
	fence_op_t dec_op;
	fence_op_t op_q;
	logic      fe_take;
	logic      fence_take;
	logic      cu_flush;

	// Decode the head instruction
	fence_decoder u_fence_decoder (
		.ins_i (fe_ins_i),
		.rs1_i (fe_rs1_i),
		.rs2_i (fe_rs2_i),
		.op_o  (dec_op)
	);

	// Front-end handshake
	assign fe_take = fe_valid_i && fe_ready_o;

	// Exception wins over decode
	assign fence_take = fe_take && !fe_except_i && (dec_op.kind != NONE);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= RESET;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			RESET: begin
				state_d = OP;
			end
			OP: begin
				if (fe_take && fe_except_i) begin
					state_d = EXCEPT;
				end else if (fence_take) begin
					state_d = ISSUE;
				end
			end
			ISSUE: begin
				// Hold valid until sequencer takes it
				if (req.ready) begin
					state_d = WAIT_SEQ;
				end
			end
			WAIT_SEQ: begin
				if (req.done) begin
					state_d = REFETCH;
				end
			end
			// Single flush cycle, then back to normal
			EXCEPT, REFETCH: begin
				state_d = OP;
			end
			default: begin
				state_d = RESET;
			end
		endcase
	end

	// Operation capture on fence acceptance
	always_ff @(posedge clk_i) begin
		if (fence_take) begin
			op_q <= dec_op;
		end
	end

	// Outputs decoded from state
	always_comb begin
		fe_ready_o = 1'b0;
		stall_o    = 1'b0;
		cu_flush   = 1'b0;
		req.valid  = 1'b0;
		case (state_q)
			OP: begin
				fe_ready_o = !be_stall_i;
			end
			ISSUE: begin
				stall_o   = 1'b1;
				req.valid = 1'b1;
			end
			WAIT_SEQ: begin
				stall_o = 1'b1;
			end
			EXCEPT, REFETCH: begin
				cu_flush = 1'b1;
			end
			default: begin
			end
		endcase
	end

	assign req.op = op_q;

	// Back-end flush passes straight through
	assign flush_o = cu_flush | be_flush_i;

endmodule

`default_nettype wire

// ==== main_cu/fence_decoder.sv ====
// Combinational decoder from instruction and operands to a fence operation
`default_nettype none

`include "sys_ctrl_defines.svh"

module fence_decoder
	import sys_ctrl_pkg::*;
(
	input  logic [`SC_ILEN-1:0] ins_i,
	input  logic [`SC_XLEN-1:0] rs1_i,
	input  logic [`SC_XLEN-1:0] rs2_i,
	output fence_op_t           op_o
);

	opcode_e                  opcode;
	logic [`SC_FUNCT3_LEN-1:0] funct3;
	logic [`SC_FUNCT7_LEN-1:0] funct7;
	logic                     rs1_is_x0;
	logic                     rs2_is_x0;

	// Standard R/I field positions
	assign opcode = opcode_e'(ins_i[`SC_OPCODE_LEN-1:0]);
	assign funct3 = ins_i[14:12];
	assign funct7 = ins_i[31:25];

	// Register index fields, not the values
	assign rs1_is_x0 = (ins_i[19:15] == 5'd0);
	assign rs2_is_x0 = (ins_i[24:20] == 5'd0);

	always_comb begin
		// Default is no fence
		op_o.kind = NONE;
		op_o.tlb  = NO_FLUSH;
		op_o.asid = '0;
		op_o.vpn  = '0;

		if (opcode == MISC_MEM && funct3 == `SC_FUNCT3_FENCE) begin
			op_o.kind = FENCE;
		end else if (opcode == MISC_MEM && funct3 == `SC_FUNCT3_FENCE_I) begin
			op_o.kind = FENCE_I;
		end else if (opcode == SYSTEM && funct3 == `SC_FUNCT3_PRIV &&
				funct7 == `SC_FUNCT7_SFENCE_VMA) begin
			op_o.kind = SFENCE_VMA;
			// Flush scope from which operands are named
			if (rs1_is_x0 && rs2_is_x0) begin
				op_o.tlb = FLUSH_ALL;
			end else if (rs1_is_x0) begin
				op_o.tlb = FLUSH_ASID;
			end else if (rs2_is_x0) begin
				op_o.tlb = FLUSH_PAGE;
			end else begin
				op_o.tlb = FLUSH_PAGE_ASID;
			end
			// ASID only when rs2 names a register
			if (!rs2_is_x0) begin
				op_o.asid = rs2_i[`SC_ASID_LEN-1:0];
			end
			// Page number only when rs1 names a register
			if (!rs1_is_x0) begin
				op_o.vpn = rs1_i[`SC_VPN_LSB +: `SC_VPN_LEN];
			end
		end
	end

endmodule

`default_nettype wire

// ==== common/fence_req_if.sv ====
// Fence request interface between main control unit and flush sequencer, with modports
`default_nettype none

interface fence_req_if
	import sys_ctrl_pkg::*;
();

	// Request held until ready
	logic      valid;
	// Sequencer idle
	logic      ready;
	// Operation to run, stable while valid
	fence_op_t op;
	// One-cycle end-of-sequence pulse
	logic      done;

	// Control unit side
	modport cu (
		output valid,
		output op,
		input  ready,
		input  done
	);

	// Sequencer side
	modport seq (
		input  valid,
		input  op,
		output ready,
		output done
	);

endinterface

`default_nettype wire

// ==== common/sys_ctrl_pkg.sv ====
// Package with opcode, fence kind, TLB flush and FSM state enums and the fence request struct
`default_nettype none

`include "sys_ctrl_defines.svh"

package sys_ctrl_pkg;

	// Major opcodes the decoder cares about
	typedef enum logic [`SC_OPCODE_LEN-1:0] {
		MISC_MEM = 7'b0001111,
		SYSTEM   = 7'b1110011
	} opcode_e;

	// Memory-ordering instruction class
	typedef enum logic [1:0] {
		NONE       = 2'd0,
		FENCE      = 2'd1,
		FENCE_I    = 2'd2,
		SFENCE_VMA = 2'd3
	} fence_kind_e;

	// TLB flush scope, shared by L1 and L2 TLB
	typedef enum logic [2:0] {
		NO_FLUSH        = 3'd0,
		FLUSH_ALL       = 3'd1,
		FLUSH_ASID      = 3'd2,
		FLUSH_PAGE      = 3'd3,
		FLUSH_PAGE_ASID = 3'd4
	} tlb_flush_e;

	typedef logic [`SC_ASID_LEN-1:0] asid_t;
	typedef logic [`SC_VPN_LEN-1:0] vpn_t;

	// Decoded fence operation
	typedef struct packed {
		fence_kind_e kind;
		tlb_flush_e  tlb;
		asid_t       asid;
		vpn_t        vpn;
	} fence_op_t;

	// Main control unit states
	typedef enum logic [2:0] {
		RESET,
		OP,
		ISSUE,
		WAIT_SEQ,
		EXCEPT,
		REFETCH
	} cu_state_e;

	// Flush sequencer states
	typedef enum logic [2:0] {
		IDLE,
		SYNC,
		IFLUSH,
		CLR_MSHR,
		TLB,
		DONE
	} seq_state_e;

endpackage

`default_nettype wire

// ==== common/sys_ctrl_defines.svh ====
// Instruction, operand, ASID and VPN widths plus fence field encodings
`ifndef SYS_CTRL_DEFINES_SVH
`define SYS_CTRL_DEFINES_SVH

// Datapath widths
`define SC_ILEN 32
`define SC_XLEN 64

// Virtual memory fields
`define SC_ASID_LEN 16
`define SC_VPN_LEN 27
// VPN starts right above the page offset
`define SC_VPN_LSB 12

// Instruction field widths
`define SC_OPCODE_LEN 7
`define SC_FUNCT3_LEN 3
`define SC_FUNCT7_LEN 7

// funct3 under MISC-MEM
`define SC_FUNCT3_FENCE 3'b000
`define SC_FUNCT3_FENCE_I 3'b001
// SFENCE.VMA sits in the PRIV group of SYSTEM
`define SC_FUNCT3_PRIV 3'b000
`define SC_FUNCT7_SFENCE_VMA 7'b0001001

`endif
